// ==== hdl/packet_ingress.sv ====
`default_nettype none

module packet_ingress #(
   parameter int unsigned NUM_RULES = 2
) (
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire                                      sop,
   input  wire                                      byte_vld,
   input  wire [regex_scan_pkg::BYTE_W-1:0]         byte_in,
   input  wire                                      eop,
   input  wire [regex_scan_pkg::STREAM_ID_W-1:0]    stream_id,
   input  wire [NUM_RULES-1:0]                      enable_mask,
   output logic                                     load_state,
   output logic                                     char_vld,
   output logic [regex_scan_pkg::BYTE_W-1:0]        char,
   output logic                                     pkt_eop,
   output logic [regex_scan_pkg::STREAM_ID_W-1:0]   pkt_stream_id,
   output logic [NUM_RULES-1:0]                     pkt_enable
);

   // High from sop until eop, tracks the outside protocol
   logic in_pkt;

   // Control strobes, each one cycle behind its input
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         load_state <= 1'b0;
         char_vld   <= 1'b0;
         pkt_eop    <= 1'b0;
         in_pkt     <= 1'b0;
      end
      else
      begin
         load_state <= sop;
         char_vld   <= byte_vld;
         pkt_eop    <= eop;
         // Packet window opens at sop and closes at eop
         if (sop)
            in_pkt <= 1'b1;
         else if (eop)
            in_pkt <= 1'b0;
      end
   end

   // Byte payload follows the strobe
   always_ff @(posedge clk)
   begin
      char <= byte_in;
   end

   // Stream id and mask are sampled only at sop
   // Held for the whole packet so eop sees the same values
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pkt_stream_id <= '0;
         pkt_enable    <= '0;
      end
      else if (sop)
      begin
         pkt_stream_id <= stream_id;
         pkt_enable    <= enable_mask;
      end
   end

   // At most one of the three input strobes per cycle
   a_strobes_exclusive : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0({sop, byte_vld, eop})
   );

   // Bytes belong inside a packet, never between eop and the next sop
   a_byte_in_packet : assert property (
      @(posedge clk) disable iff (!rst_n)
      byte_vld |-> in_pkt
   );

endmodule : packet_ingress

`default_nettype wire

// ==== hdl/regex_dfa.sv ====
`default_nettype none

module regex_dfa #(
   parameter logic [regex_scan_pkg::MAX_PATTERN_LEN*regex_scan_pkg::BYTE_W-1:0] PATTERN = '0,
   parameter int unsigned PATTERN_LEN = 1
) (
   input  wire                                   clk,
   input  wire                                   rst_n,
   input  wire [regex_scan_pkg::BYTE_W-1:0]      char,
   input  wire                                   char_vld,
   input  wire [regex_scan_pkg::STATE_W-1:0]     state_in,
   input  wire                                   state_in_vld,
   output logic [regex_scan_pkg::STATE_W-1:0]    state_out,
   output logic                                  accept_out
);

   // Bits needed to pick one byte out of the pattern
   localparam int unsigned IDX_W = $clog2(regex_scan_pkg::MAX_PATTERN_LEN);

   localparam logic [regex_scan_pkg::STATE_W-1:0] LEN_S =
      regex_scan_pkg::STATE_W'(PATTERN_LEN);

   // Pattern byte i sits at bits [i*BYTE_W +: BYTE_W], byte 0 lowest
   localparam logic [regex_scan_pkg::BYTE_W-1:0] FIRST_BYTE =
      PATTERN[regex_scan_pkg::BYTE_W-1:0];

   logic [regex_scan_pkg::BYTE_W-1:0]  expect_byte;
   logic [regex_scan_pkg::STATE_W-1:0] state_adv;
   logic [regex_scan_pkg::STATE_W-1:0] state_nxt;
   logic                               accept_nxt;

   // Next byte the literal wants in the current state
   assign expect_byte = PATTERN[state_out[IDX_W-1:0]*regex_scan_pkg::BYTE_W +:
                                regex_scan_pkg::BYTE_W];

   assign state_adv = state_out + 1'b1;

   // Step on one byte
   always_comb
   begin
      state_nxt  = '0;
      accept_nxt = 1'b0;
      if (char == expect_byte)
      begin
         // Full literal seen, fire and start over
         if (state_adv == LEN_S)
         begin
            accept_nxt = 1'b1;
            state_nxt  = '0;
         end
         else
            state_nxt = state_adv;
      end
      // Mismatch, the byte may still open a new match
      // Exact because the literal has no self-overlapping prefix
      else if (char == FIRST_BYTE)
         state_nxt = regex_scan_pkg::STATE_W'(1);
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out  <= '0;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         // Restore wins over a byte in the same cycle
         if (state_in_vld)
            state_out <= state_in;
         else if (char_vld)
         begin
            state_out  <= state_nxt;
            accept_out <= accept_nxt;
         end
      end
   end

   // Restored states come from the unit memory, they must still be in range
   a_state_in_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      state_out <= LEN_S
   );

endmodule : regex_dfa

`default_nettype wire

// ==== hdl/regex_scan_pkg.sv ====
`default_nettype none

package regex_scan_pkg;

   // Payload byte width
   localparam int unsigned BYTE_W = 8;

   // Stream id width, 64 interleaved streams
   localparam int unsigned STREAM_ID_W = 6;

   // Depth of every per-stream state memory
   localparam int unsigned NUM_STREAMS = 64;

   // DFA state is the count of pattern bytes matched so far
   // Holds 0 to 8, so 4 bits
   localparam int unsigned STATE_W = 4;

   // Per-rule packet counter width
   localparam int unsigned COUNT_W = 16;

   // Longest literal a rule can hold
   // Shorter literals are zero padded in the upper bytes
   localparam int unsigned MAX_PATTERN_LEN = 8;

endpackage : regex_scan_pkg

`default_nettype wire

// ==== hdl/regex_scan_top.sv ====
`default_nettype none

module regex_scan_top #(
   parameter int unsigned NUM_RULES = 2,
   // Rule r literal at [r*64 +: 64], its byte 0 in the lowest bits
   // Defaults are "abc" and "x1y2z"
   parameter logic [NUM_RULES*regex_scan_pkg::MAX_PATTERN_LEN*regex_scan_pkg::BYTE_W-1:0]
      PATTERNS = {64'h0000_007a_3279_3178, 64'h0000_0000_0063_6261},
   // Rule r length at [r*STATE_W +: STATE_W]
   parameter logic [NUM_RULES*regex_scan_pkg::STATE_W-1:0] PATTERN_LENS = {4'd5, 4'd3}
) (
   input  wire                                        clk,
   input  wire                                        rst_n,
   input  wire                                        sop,
   input  wire                                        byte_vld,
   input  wire [regex_scan_pkg::BYTE_W-1:0]           byte_in,
   input  wire                                        eop,
   input  wire [regex_scan_pkg::STREAM_ID_W-1:0]      stream_id,
   input  wire [NUM_RULES-1:0]                        enable_mask,
   output logic [NUM_RULES*regex_scan_pkg::COUNT_W-1:0] counts,
   output logic [NUM_RULES-1:0]                       fired
);

   localparam int unsigned PAT_W = regex_scan_pkg::MAX_PATTERN_LEN * regex_scan_pkg::BYTE_W;

   // Registered packet stream shared by all rules
   logic                                   load_state;
   logic                                   char_vld;
   logic [regex_scan_pkg::BYTE_W-1:0]      char;
   logic                                   pkt_eop;
   logic [regex_scan_pkg::STREAM_ID_W-1:0] pkt_stream_id;
   logic [NUM_RULES-1:0]                   pkt_enable;

   packet_ingress #(
      .NUM_RULES (NUM_RULES)
   ) packet_ingress_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .sop           (sop),
      .byte_vld      (byte_vld),
      .byte_in       (byte_in),
      .eop           (eop),
      .stream_id     (stream_id),
      .enable_mask   (enable_mask),
      .load_state    (load_state),
      .char_vld      (char_vld),
      .char          (char),
      .pkt_eop       (pkt_eop),
      .pkt_stream_id (pkt_stream_id),
      .pkt_enable    (pkt_enable)
   );

   // One unit per rule, each with its own literal and enable bit
   for (genvar r = 0; r < NUM_RULES; r++)
   begin : g_rule
      stream_rule_unit #(
         .PATTERN     (PATTERNS[r*PAT_W +: PAT_W]),
         .PATTERN_LEN (PATTERN_LENS[r*regex_scan_pkg::STATE_W +: regex_scan_pkg::STATE_W])
      ) stream_rule_unit_i (
         .clk           (clk),
         .rst_n         (rst_n),
         .load_state    (load_state),
         .char_vld      (char_vld),
         .char          (char),
         .pkt_eop       (pkt_eop),
         .pkt_stream_id (pkt_stream_id),
         .pkt_enable    (pkt_enable[r]),
         .count         (counts[r*regex_scan_pkg::COUNT_W +: regex_scan_pkg::COUNT_W]),
         .fired         (fired[r])
      );
   end

endmodule : regex_scan_top

`default_nettype wire

// ==== hdl/stream_rule_unit.sv ====
`default_nettype none

module stream_rule_unit #(
   parameter logic [regex_scan_pkg::MAX_PATTERN_LEN*regex_scan_pkg::BYTE_W-1:0] PATTERN = '0,
   parameter int unsigned PATTERN_LEN = 1
) (
   input  wire                                     clk,
   input  wire                                     rst_n,
   input  wire                                     load_state,
   input  wire                                     char_vld,
   input  wire [regex_scan_pkg::BYTE_W-1:0]        char,
   input  wire                                     pkt_eop,
   input  wire [regex_scan_pkg::STREAM_ID_W-1:0]   pkt_stream_id,
   input  wire                                     pkt_enable,
   output logic [regex_scan_pkg::COUNT_W-1:0]      count,
   output logic                                    fired
);

   // Saved DFA state per stream
   logic [regex_scan_pkg::STATE_W-1:0] state_mem [regex_scan_pkg::NUM_STREAMS];

   // Stream has ended at least one enabled packet
   logic [regex_scan_pkg::NUM_STREAMS-1:0] seen;

   // Restore path into the DFA
   logic [regex_scan_pkg::STATE_W-1:0] state_in;
   logic                               state_in_vld;

   logic [regex_scan_pkg::STATE_W-1:0] state_out;
   logic                               accept_out;

   // Restore one cycle after load_state
   // Unseen streams start from state 0
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   always_ff @(posedge clk)
   begin
      if (load_state)
         state_in <= seen[pkt_stream_id] ? state_mem[pkt_stream_id] : '0;
   end

   // Save the DFA state at the end of an enabled packet
   always_ff @(posedge clk)
   begin
      if (pkt_eop && pkt_enable)
         state_mem[pkt_stream_id] <= state_out;
   end

   // Seen bits, fired flag and packet counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen  <= '0;
         fired <= 1'b0;
         count <= '0;
      end
      else
      begin
         // New packet clears the flag, any match sets it
         if (load_state)
            fired <= 1'b0;
         else if (accept_out)
            fired <= 1'b1;
         if (pkt_eop)
         begin
            if (pkt_enable)
            begin
               // One count per packet, however many matches
               count               <= count + regex_scan_pkg::COUNT_W'(fired);
               seen[pkt_stream_id] <= 1'b1;
            end
            else
               // Disabled rule, the stream keeps its old saved state
               fired <= 1'b0;
         end
      end
   end

   regex_dfa #(
      .PATTERN     (PATTERN),
      .PATTERN_LEN (PATTERN_LEN)
   ) regex_dfa_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .char         (char),
      .char_vld     (char_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

   // Save and restore on the same stream id must not overlap
   a_eop_load_apart : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(pkt_eop && load_state)
   );

endmodule : stream_rule_unit

`default_nettype wire

// ==== regex_scan.f ====
hdl/regex_scan_pkg.sv
hdl/packet_ingress.sv
hdl/regex_dfa.sv
hdl/stream_rule_unit.sv
hdl/regex_scan_top.sv
testbench/regex_scan_tb.sv

// ==== testbench/regex_scan_tb.sv ====
`default_nettype none

module regex_scan_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned NUM_RULES = 2;
   localparam int unsigned COUNT_W = regex_scan_pkg::COUNT_W;
   localparam int unsigned STREAM_ID_W = regex_scan_pkg::STREAM_ID_W;
   localparam TRACE_FILE = "testbench/regex_scan_trace.txt";

   logic                                  clk;
   logic                                  rst_n;
   logic                                  sop;
   logic                                  byte_vld;
   logic [regex_scan_pkg::BYTE_W-1:0]     byte_in;
   logic                                  eop;
   logic [STREAM_ID_W-1:0]                stream_id;
   logic [NUM_RULES-1:0]                  enable_mask;
   logic [NUM_RULES*COUNT_W-1:0]          counts;
   logic [NUM_RULES-1:0]                  fired;

   // Seed for the extra idle gaps
   integer seed;

   // Run bookkeeping
   int    cycles = 0;
   int    cycle_limit = 0;
   int    checks = 0;
   int    errors = 0;
   int    test_errors = 0;
   int    tests_done = 0;
   string current_test = "";

   regex_scan_top #(
      .NUM_RULES (NUM_RULES)
   ) dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .sop         (sop),
      .byte_vld    (byte_vld),
      .byte_in     (byte_in),
      .eop         (eop),
      .stream_id   (stream_id),
      .enable_mask (enable_mask),
      .counts      (counts),
      .fired       (fired)
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Cycle guard with its limit set once the trace length is known
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("timeout: trace did not finish");
         $display("** FAIL **");
         $finish;
      end
   end

   // Extra spacing of 0 to 3 cycles on top of the protocol minimum
   function automatic int random_gap();
      return $unsigned($random(seed)) % 4;
   endfunction

   // Drop line ends and trailing blanks
   function automatic string trim_line(input string s);
      string t;
      t = s;
      while (t.len() > 0 && (t[t.len()-1] == "\n" || t[t.len()-1] == "\r" ||
                             t[t.len()-1] == " "))
         t = t.substr(0, t.len() - 2);
      return t;
   endfunction

   // Blank lines and # comments carry no record
   function automatic bit is_record(input string s);
      return s.len() > 0 && s[0] != "#";
   endfunction

   task automatic drive_idle(input int n);
      repeat (n)
      begin
         @(negedge clk);
         sop      = 1'b0;
         byte_vld = 1'b0;
         eop      = 1'b0;
      end
   endtask

   // Stream id and mask only matter during the sop cycle
   task automatic drive_sop(input logic [STREAM_ID_W-1:0] id,
                            input logic [NUM_RULES-1:0] mask);
      @(negedge clk);
      sop         = 1'b1;
      byte_vld    = 1'b0;
      eop         = 1'b0;
      stream_id   = id;
      enable_mask = mask;
   endtask

   task automatic drive_byte(input logic [regex_scan_pkg::BYTE_W-1:0] b);
      @(negedge clk);
      sop      = 1'b0;
      byte_vld = 1'b1;
      byte_in  = b;
      eop      = 1'b0;
   endtask

   task automatic drive_eop();
      @(negedge clk);
      sop      = 1'b0;
      byte_vld = 1'b0;
      eop      = 1'b1;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected)
      begin
         $display("ERR %s got 0x%0h expected 0x%0h", name, got, expected);
         errors++;
         test_errors++;
      end
   endtask

   // One line per finished test
   task automatic close_test();
      if (current_test.len() > 0)
      begin
         if (test_errors == 0)
            $display("test %s done, ok", current_test);
         else
            $display("test %s done, %0d errors", current_test, test_errors);
         tests_done++;
      end
      test_errors = 0;
   endtask

   task automatic count_records(output int n);
      int    fd;
      string line;
      n = -1;
      fd = $fopen(TRACE_FILE, "r");
      if (fd != 0)
      begin
         n = 0;
         while ($fgets(line, fd) != 0)
         begin
            line = trim_line(line);
            if (is_record(line))
               n++;
         end
         $fclose(fd);
      end
   endtask

   task automatic run_record(input string line);
      logic [7:0]  kind;
      logic [31:0] a;
      logic [31:0] b;
      int          fields;
      kind = line[0];
      a = '0;
      b = '0;
      fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
      if ((kind == "S" || kind == "C" || kind == "F") && fields != 2)
      begin
         $display("trace record is missing fields: %s", line);
         errors++;
         test_errors++;
      end
      else
         case (kind)
            "S":
            begin
               drive_sop(a[STREAM_ID_W-1:0], b[NUM_RULES-1:0]);
               drive_idle(1 + random_gap());
            end
            "B":
            begin
               drive_byte(a[regex_scan_pkg::BYTE_W-1:0]);
               drive_idle(random_gap());
            end
            "E":
            begin
               // Last byte needs 2 cycles to reach the fired flag
               drive_idle(1 + random_gap());
               drive_eop();
               // Count settles 2 cycles after eop
               drive_idle(2 + random_gap());
            end
            "W":
               drive_idle(a);
            "C":
               check_value($sformatf("counts[%0d]", a), counts[a*COUNT_W +: COUNT_W], b);
            "F":
               check_value($sformatf("fired[%0d]", a), fired[a], b);
            "T":
            begin
               close_test();
               current_test = line.substr(2, line.len() - 1);
            end
            default:
            begin
               $display("unknown trace record: %s", line);
               errors++;
               test_errors++;
            end
         endcase
   endtask

   initial
   begin
      int    n_records;
      int    fd;
      string line;
      seed        = 32'h4d4f_ca9b;
      rst_n       = 1'b0;
      sop         = 1'b0;
      byte_vld    = 1'b0;
      byte_in     = '0;
      eop         = 1'b0;
      stream_id   = '0;
      enable_mask = '0;
      count_records(n_records);
      // Each record takes at most a few cycles plus reset and margin
      cycle_limit = (n_records > 0 ? n_records : 0) * 8 + 100;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0)
      begin
         $display("cannot open trace file %s", TRACE_FILE);
         errors++;
      end
      else
      begin
         drive_idle(16);
         rst_n = 1'b1;
         while ($fgets(line, fd) != 0)
         begin
            line = trim_line(line);
            if (is_record(line))
               run_record(line);
         end
         $fclose(fd);
         close_test();
      end
      if (checks == 0)
      begin
         $display("trace held no checks");
         errors++;
      end
      $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule : regex_scan_tb

`default_nettype wire

// ==== testbench/regex_scan_trace.txt ====
# S stream mask | B byte | E | W cycles | C rule count | F rule fired | T test name
# Values in hex, rule 0 is "abc", rule 1 is "x1y2z"
T reset
C 0 0
C 1 0
F 0 0
F 1 0
T one_per_packet
S 01 3
B 61
B 62
B 63
B 61
B 62
B 63
E
C 0 1
C 1 0
F 0 1
T cross_packet
S 05 3
B 78
B 31
B 79
E
S 09 3
B 32
B 7a
E
C 1 0
S 05 3
B 32
B 7a
E
C 1 1
F 1 1
C 0 1
T disabled
S 02 2
B 61
B 62
B 63
E
C 0 1
F 0 0
C 1 1
T fresh_stream
S 14 3
B 61
E
S 15 3
B 62
B 63
E
C 0 1
F 0 0
T fallback
S 16 1
B 61
B 61
B 62
B 63
E
C 0 2
F 0 1
S 17 1
B 61
B 62
B 61
B 63
E
C 0 2
F 0 0
C 1 1
